//--- design/dvs_hssl_pkg.sv
// packet layout, packet type enum, register address map and bus widths
package dvs_hssl_pkg;

  // ------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------
  // sensor event word from the event source
  localparam int evt_bits = 32;
  // routing key carried in every packet
  localparam int key_bits = 32;
  // register data and packet payload
  localparam int data_bits = 32;
  // register word address
  localparam int addr_bits = 8;
  // mapper right-shift amount
  localparam int shift_bits = 3;

  // ------------------------------------------------------------
  // packet layout, top bit down
  //   [71:64] header
  //   [63:32] key
  //   [31:0]  payload
  // ------------------------------------------------------------
  localparam int hdr_bits    = 8;
  localparam int type_bits   = 2;
  localparam int pkt_bits    = hdr_bits + key_bits + data_bits;
  localparam int payload_lsb = 0;
  localparam int key_lsb     = payload_lsb + data_bits;
  localparam int hdr_lsb     = key_lsb + key_bits;

  // packet type in header bits 1:0
  // upper header bits are always zero
  // codes 0 and 3 unused, receiver ignores them
  typedef enum logic [type_bits-1:0] {
    pkt_mc  = 2'd1,
    pkt_cfg = 2'd2
  } pkt_type_e;

  // ------------------------------------------------------------
  // register map, word addresses
  // ------------------------------------------------------------
  // bit 0 is stop
  localparam int addr_ctrl    = 0;
  // packet counters, read only
  localparam int addr_cnt_mc  = 1;
  localparam int addr_cnt_cfg = 2;
  // mapper tables, one word per entry
  localparam int addr_map_mask  = 4;
  localparam int addr_map_shift = 8;
  // routing table, one word per entry
  localparam int addr_rt_key   = 16;
  localparam int addr_rt_mask  = 32;
  localparam int addr_rt_route = 48;
  // anything else is unmapped

endpackage

//--- design/dvs_hssl_top.sv
// event-to-packet bridge: register bank, assembler, router and receiver
module dvs_hssl_top #(
  parameter int num_mregs    = 4,
  parameter int num_rregs    = 16,
  parameter int num_channels = 3
) (
  input  logic                                 pl_clk0_buf_int,
  input  logic                                 rst_n,
  // apb slave
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [dvs_hssl_pkg::addr_bits-1:0]   paddr,
  input  logic [dvs_hssl_pkg::data_bits-1:0]   pwdata,
  output logic [dvs_hssl_pkg::data_bits-1:0]   prdata,
  output logic                                 pslverr,
  // sensor events
  input  logic [dvs_hssl_pkg::evt_bits-1:0]    evt_data,
  input  logic                                 evt_vld,
  output logic                                 evt_rdy,
  // multicast transmit channels
  output logic [dvs_hssl_pkg::pkt_bits-1:0]    tx_data,
  output logic [num_channels-1:0]              tx_vld,
  input  logic [num_channels-1:0]              tx_rdy,
  // receive path
  input  logic [dvs_hssl_pkg::pkt_bits-1:0]    rx_data,
  input  logic                                 rx_vld
);

  // ------------------------------------------------------------
  // internal signals
  // ------------------------------------------------------------
  logic                                  stop;
  logic [dvs_hssl_pkg::evt_bits-1:0]     map_mask  [num_mregs];
  logic [dvs_hssl_pkg::shift_bits-1:0]   map_shift [num_mregs];
  logic [dvs_hssl_pkg::key_bits-1:0]     rt_key    [num_rregs];
  logic [dvs_hssl_pkg::key_bits-1:0]     rt_mask   [num_rregs];
  logic [num_channels-1:0]               rt_route  [num_rregs];
  // assembler to router
  logic [dvs_hssl_pkg::pkt_bits-1:0]     pkt_data;
  logic                                  pkt_vld;
  logic                                  pkt_rdy;
  // receiver to register bank
  logic [dvs_hssl_pkg::addr_bits-1:0]    cfg_addr;
  logic [dvs_hssl_pkg::data_bits-1:0]    cfg_data;
  logic                                  cfg_wr;
  logic                                  cnt_mc;
  logic                                  cnt_cfg;

  // control registers, written by apb and config packets
  dvs_reg_bank #(
      .num_mregs    (num_mregs)
    , .num_rregs    (num_rregs)
    , .num_channels (num_channels)
  ) i_reg_bank (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .psel            (psel)
    , .penable         (penable)
    , .pwrite          (pwrite)
    , .paddr           (paddr)
    , .pwdata          (pwdata)
    , .prdata          (prdata)
    , .pslverr         (pslverr)
    , .cfg_addr        (cfg_addr)
    , .cfg_data        (cfg_data)
    , .cfg_wr          (cfg_wr)
    , .cnt_mc          (cnt_mc)
    , .cnt_cfg         (cnt_cfg)
    , .stop            (stop)
    , .map_mask        (map_mask)
    , .map_shift       (map_shift)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
  );

  // events in, keyed packets out
  evt_pkt_assembler #(
      .num_mregs (num_mregs)
  ) i_assembler (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .stop            (stop)
    , .map_mask        (map_mask)
    , .map_shift       (map_shift)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .pkt_data        (pkt_data)
    , .pkt_vld         (pkt_vld)
    , .pkt_rdy         (pkt_rdy)
  );

  // multicast to the transmit channels
  pkt_router #(
      .num_rregs    (num_rregs)
    , .num_channels (num_channels)
  ) i_router (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
    , .pkt_data        (pkt_data)
    , .pkt_vld         (pkt_vld)
    , .pkt_rdy         (pkt_rdy)
    , .tx_data         (tx_data)
    , .tx_vld          (tx_vld)
    , .tx_rdy          (tx_rdy)
  );

  // received packets become config writes and counts
  pkt_receiver i_receiver (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rx_data         (rx_data)
    , .rx_vld          (rx_vld)
    , .cfg_addr        (cfg_addr)
    , .cfg_data        (cfg_data)
    , .cfg_wr          (cfg_wr)
    , .cnt_mc          (cnt_mc)
    , .cnt_cfg         (cnt_cfg)
  );

endmodule

//--- design/dvs_reg_bank.sv
// APB register bank: control, mapper, routing table and packet counter registers
module dvs_reg_bank #(
  parameter int num_mregs    = 4,
  parameter int num_rregs    = 16,
  parameter int num_channels = 3
) (
  input  logic                                  pl_clk0_buf_int,
  input  logic                                  rst_n,
  // apb slave, always zero wait states
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [dvs_hssl_pkg::addr_bits-1:0]    paddr,
  input  logic [dvs_hssl_pkg::data_bits-1:0]    pwdata,
  output logic [dvs_hssl_pkg::data_bits-1:0]    prdata,
  output logic                                  pslverr,
  // writes decoded from received config packets
  input  logic [dvs_hssl_pkg::addr_bits-1:0]    cfg_addr,
  input  logic [dvs_hssl_pkg::data_bits-1:0]    cfg_data,
  input  logic                                  cfg_wr,
  // counter increment pulses
  input  logic                                  cnt_mc,
  input  logic                                  cnt_cfg,
  // register outputs
  output logic                                  stop,
  output logic [dvs_hssl_pkg::evt_bits-1:0]     map_mask  [num_mregs],
  output logic [dvs_hssl_pkg::shift_bits-1:0]   map_shift [num_mregs],
  output logic [dvs_hssl_pkg::key_bits-1:0]     rt_key    [num_rregs],
  output logic [dvs_hssl_pkg::key_bits-1:0]     rt_mask   [num_rregs],
  output logic [num_channels-1:0]               rt_route  [num_rregs]
);

  logic                                apb_wr;
  logic                                rd_hit;
  logic [dvs_hssl_pkg::data_bits-1:0]  cnt_mc_q;
  logic [dvs_hssl_pkg::data_bits-1:0]  cnt_cfg_q;

  // write lands at the end of the access cycle
  assign apb_wr = psel & penable & pwrite;

  // register at word address a written this cycle, by either port
  function automatic logic wr_hit(input int a);
    return (apb_wr && int'(paddr) == a) || (cfg_wr && int'(cfg_addr) == a);
  endfunction

  // apb data has priority on a collision
  function automatic logic [dvs_hssl_pkg::data_bits-1:0] wr_val(input int a);
    return (apb_wr && int'(paddr) == a) ? pwdata : cfg_data;
  endfunction

  // ------------------------------------------------------------
  // writable registers
  // ------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      stop <= 1'b0;
      for (int i = 0; i < num_mregs; i++) begin
        map_mask[i]  <= '0;
        map_shift[i] <= '0;
      end
      // zero table, every key hits entry 0 with an empty route
      for (int i = 0; i < num_rregs; i++) begin
        rt_key[i]   <= '0;
        rt_mask[i]  <= '0;
        rt_route[i] <= '0;
      end
    end else begin
      if (wr_hit(dvs_hssl_pkg::addr_ctrl))
        stop <= 1'(wr_val(dvs_hssl_pkg::addr_ctrl));
      for (int i = 0; i < num_mregs; i++) begin
        if (wr_hit(dvs_hssl_pkg::addr_map_mask + i))
          map_mask[i] <= wr_val(dvs_hssl_pkg::addr_map_mask + i);
        if (wr_hit(dvs_hssl_pkg::addr_map_shift + i))
          map_shift[i] <= dvs_hssl_pkg::shift_bits'(wr_val(dvs_hssl_pkg::addr_map_shift + i));
      end
      for (int i = 0; i < num_rregs; i++) begin
        if (wr_hit(dvs_hssl_pkg::addr_rt_key + i))
          rt_key[i] <= wr_val(dvs_hssl_pkg::addr_rt_key + i);
        if (wr_hit(dvs_hssl_pkg::addr_rt_mask + i))
          rt_mask[i] <= wr_val(dvs_hssl_pkg::addr_rt_mask + i);
        if (wr_hit(dvs_hssl_pkg::addr_rt_route + i))
          rt_route[i] <= num_channels'(wr_val(dvs_hssl_pkg::addr_rt_route + i));
      end
    end
  end

  // packet counters, free running and wrapping
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      cnt_mc_q  <= '0;
      cnt_cfg_q <= '0;
    end else begin
      if (cnt_mc)
        cnt_mc_q <= cnt_mc_q + 1'b1;
      if (cnt_cfg)
        cnt_cfg_q <= cnt_cfg_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // read mux, combinational during the access cycle
  // ------------------------------------------------------------
  always_comb begin
    prdata = '0;
    rd_hit = 1'b0;
    if (int'(paddr) == dvs_hssl_pkg::addr_ctrl) begin
      rd_hit    = 1'b1;
      prdata[0] = stop;
    end
    if (int'(paddr) == dvs_hssl_pkg::addr_cnt_mc) begin
      rd_hit = 1'b1;
      prdata = cnt_mc_q;
    end
    if (int'(paddr) == dvs_hssl_pkg::addr_cnt_cfg) begin
      rd_hit = 1'b1;
      prdata = cnt_cfg_q;
    end
    for (int i = 0; i < num_mregs; i++) begin
      if (int'(paddr) == dvs_hssl_pkg::addr_map_mask + i) begin
        rd_hit = 1'b1;
        prdata = map_mask[i];
      end
      if (int'(paddr) == dvs_hssl_pkg::addr_map_shift + i) begin
        rd_hit = 1'b1;
        prdata[dvs_hssl_pkg::shift_bits-1:0] = map_shift[i];
      end
    end
    for (int i = 0; i < num_rregs; i++) begin
      if (int'(paddr) == dvs_hssl_pkg::addr_rt_key + i) begin
        rd_hit = 1'b1;
        prdata = rt_key[i];
      end
      if (int'(paddr) == dvs_hssl_pkg::addr_rt_mask + i) begin
        rd_hit = 1'b1;
        prdata = rt_mask[i];
      end
      if (int'(paddr) == dvs_hssl_pkg::addr_rt_route + i) begin
        rd_hit = 1'b1;
        prdata[num_channels-1:0] = rt_route[i];
      end
    end
  end

  // unmapped address flagged in the access cycle
  assign pslverr = psel & penable & ~rd_hit;

endmodule

//--- design/evt_pkt_assembler.sv
// event mapper: turns sensor events into keyed multicast packets
module evt_pkt_assembler #(
  parameter int num_mregs = 4
) (
  input  logic                                  pl_clk0_buf_int,
  input  logic                                  rst_n,
  input  logic                                  stop,
  // mapper registers
  input  logic [dvs_hssl_pkg::evt_bits-1:0]     map_mask  [num_mregs],
  input  logic [dvs_hssl_pkg::shift_bits-1:0]   map_shift [num_mregs],
  // incoming events
  input  logic [dvs_hssl_pkg::evt_bits-1:0]     evt_data,
  input  logic                                  evt_vld,
  output logic                                  evt_rdy,
  // assembled packet to the router
  output logic [dvs_hssl_pkg::pkt_bits-1:0]     pkt_data,
  output logic                                  pkt_vld,
  input  logic                                  pkt_rdy
);

  logic [dvs_hssl_pkg::key_bits-1:0]  key;
  logic                               evt_take;

  // key is the OR of every masked and shifted field
  always_comb begin
    key = '0;
    for (int i = 0; i < num_mregs; i++)
      key = key | ((evt_data & map_mask[i]) >> map_shift[i]);
  end

  // take an event when the output slot is free or draining
  // stop holds off the source
  assign evt_rdy  = ~stop & (~pkt_vld | pkt_rdy);
  assign evt_take = evt_vld & evt_rdy;

  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n)
      pkt_vld <= 1'b0;
    else if (evt_take)
      pkt_vld <= 1'b1;
    else if (pkt_rdy)
      pkt_vld <= 1'b0;
  end

  // header, key, then the raw event as payload
  always_ff @(posedge pl_clk0_buf_int) begin
    if (evt_take)
      pkt_data <= {{(dvs_hssl_pkg::hdr_bits - dvs_hssl_pkg::type_bits){1'b0}},
                   dvs_hssl_pkg::pkt_mc, key, evt_data};
  end

endmodule

//--- design/pkt_receiver.sv
// receive packet decoder: config writes and packet counter pulses
module pkt_receiver (
  input  logic                                 pl_clk0_buf_int,
  input  logic                                 rst_n,
  // received packets, one per cycle
  input  logic [dvs_hssl_pkg::pkt_bits-1:0]    rx_data,
  input  logic                                 rx_vld,
  // register write to the bank
  output logic [dvs_hssl_pkg::addr_bits-1:0]   cfg_addr,
  output logic [dvs_hssl_pkg::data_bits-1:0]   cfg_data,
  output logic                                 cfg_wr,
  // counter pulses
  output logic                                 cnt_mc,
  output logic                                 cnt_cfg
);

  dvs_hssl_pkg::pkt_type_e rx_type;

  assign rx_type = dvs_hssl_pkg::pkt_type_e'(
                     rx_data[dvs_hssl_pkg::hdr_lsb +: dvs_hssl_pkg::type_bits]);

  // one-cycle pulses, a cycle after the packet
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      cfg_wr  <= 1'b0;
      cnt_mc  <= 1'b0;
      cnt_cfg <= 1'b0;
    end else begin
      cfg_wr  <= 1'b0;
      cnt_mc  <= 1'b0;
      cnt_cfg <= 1'b0;
      if (rx_vld) begin
        case (rx_type)
          dvs_hssl_pkg::pkt_mc:  cnt_mc <= 1'b1;
          dvs_hssl_pkg::pkt_cfg: begin
            cfg_wr  <= 1'b1;
            cnt_cfg <= 1'b1;
          end
          // unknown types dropped
          default: ;
        endcase
      end
    end
  end

  // address from the low key byte, data from the payload
  always_ff @(posedge pl_clk0_buf_int) begin
    if (rx_vld) begin
      cfg_addr <= rx_data[dvs_hssl_pkg::key_lsb +: dvs_hssl_pkg::addr_bits];
      cfg_data <= rx_data[dvs_hssl_pkg::payload_lsb +: dvs_hssl_pkg::data_bits];
    end
  end

endmodule

//--- design/pkt_router.sv
// routing table lookup and multicast transmit stage
module pkt_router #(
  parameter int num_rregs    = 16,
  parameter int num_channels = 3
) (
  input  logic                                pl_clk0_buf_int,
  input  logic                                rst_n,
  // routing table
  input  logic [dvs_hssl_pkg::key_bits-1:0]   rt_key   [num_rregs],
  input  logic [dvs_hssl_pkg::key_bits-1:0]   rt_mask  [num_rregs],
  input  logic [num_channels-1:0]             rt_route [num_rregs],
  // assembled packet
  input  logic [dvs_hssl_pkg::pkt_bits-1:0]   pkt_data,
  input  logic                                pkt_vld,
  output logic                                pkt_rdy,
  // shared data bus, one handshake per channel
  output logic [dvs_hssl_pkg::pkt_bits-1:0]   tx_data,
  output logic [num_channels-1:0]             tx_vld,
  input  logic [num_channels-1:0]             tx_rdy
);

  logic [dvs_hssl_pkg::key_bits-1:0]  pkt_key;
  logic [num_channels-1:0]            route_sel;
  logic [num_channels-1:0]            pending;
  logic                               pkt_take;

  assign pkt_key = pkt_data[dvs_hssl_pkg::key_lsb +: dvs_hssl_pkg::key_bits];

  // ------------------------------------------------------------
  // key/mask match
  // ------------------------------------------------------------
  // scan from the top so the lowest matching entry wins
  // no match leaves an empty route and the packet is dropped
  always_comb begin
    route_sel = '0;
    for (int i = num_rregs - 1; i >= 0; i--) begin
      if ((pkt_key & rt_mask[i]) == rt_key[i])
        route_sel = rt_route[i];
    end
  end

  // ------------------------------------------------------------
  // multicast output
  // ------------------------------------------------------------
  // one packet in flight, next one waits for all channels
  assign pkt_rdy  = ~|pending;
  assign pkt_take = pkt_vld & pkt_rdy;

  // each pending bit is one channel still to deliver
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n)
      pending <= '0;
    else if (pkt_take)
      pending <= route_sel;
    else
      pending <= pending & ~tx_rdy;
  end

  // data held until every channel has taken it
  always_ff @(posedge pl_clk0_buf_int) begin
    if (pkt_take)
      tx_data <= pkt_data;
  end

  assign tx_vld = pending;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dvs_hssl -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- tb.f
+incdir+include
design/dvs_hssl_pkg.sv
design/dvs_reg_bank.sv
design/evt_pkt_assembler.sv
design/pkt_router.sv
design/pkt_receiver.sv
design/dvs_hssl_top.sv
verification/tb_dvs_hssl.sv

//--- include/tb_dvs_hssl_table.svh
// stimulus and expected-value table loaded into the testbench queues
// each row holds op, address, data, expected value and test name
//   rd    expected read data
//   evt   expected is the latency, 0 leaves it unchecked
//   evt   address 1 randomizes bits outside 11:4
//   wait  data is the cycle count, 0 drains first
//   wait  expected is {evt_rdy, tx_vld}
task automatic load_table();
  // reset state
  add_row(op_rd,   0, 0, 0, "reset_ctrl");
  add_row(op_rd,   1, 0, 0, "reset_cnt_mc");
  add_row(op_rd,   2, 0, 0, "reset_cnt_cfg");
  add_row(op_wait, 0, 2, 4'b1000, "reset_status");
  // mapper gives key[7:0] = evt[11:4]
  add_row(op_wr,   4, 32'h0000_00f0, 0, "map_mask0");
  add_row(op_wr,   8, 4, 0, "map_shift0");
  add_row(op_wr,   5, 32'h0000_0f00, 0, "map_mask1");
  add_row(op_wr,   9, 4, 0, "map_shift1");
  // entry 0 key 0x12 to ch0 and ch2, entry 1 keys 0x3x to ch0 and ch1
  add_row(op_wr,  16, 32'h0000_0012, 0, "rt_key0");
  add_row(op_wr,  32, 32'h0000_00ff, 0, "rt_mask0");
  add_row(op_wr,  48, 3'b101, 0, "rt_route0");
  add_row(op_wr,  17, 32'h0000_0030, 0, "rt_key1");
  add_row(op_wr,  33, 32'h0000_00f0, 0, "rt_mask1");
  add_row(op_wr,  49, 3'b011, 0, "rt_route1");
  // zero mask against an all-ones key never matches
  for (int i = 2; i < 16; i++)
    add_row(op_wr, 16 + i, 32'hffff_ffff, 0, "rt_key_unused");
  add_row(op_rd,   5, 0, 32'h0000_0f00, "map_mask1_rd");
  add_row(op_rd,   9, 0, 4, "map_shift1_rd");
  add_row(op_rd,  16, 0, 32'h0000_0012, "rt_key0_rd");
  add_row(op_rd,  33, 0, 32'h0000_00f0, "rt_mask1_rd");
  add_row(op_rd,  48, 0, 3'b101, "rt_route0_rd");
  add_row(op_rd,   3, 0, 0, "unmapped_3_rd");
  add_row(op_rd, 255, 0, 0, "unmapped_255_rd");
  // mapping and multicast
  add_row(op_rdy,  0, 3'b111, 0, "all_ready");
  add_row(op_evt,  0, 32'hab00_0120, 2, "evt_ch02");
  add_row(op_wait, 0, 0, 4'b1000, "drain_ch02");
  add_row(op_evt,  0, 32'h0000_0350, 2, "evt_ch01");
  add_row(op_evt,  0, 32'h0000_0770, 0, "evt_no_match");
  add_row(op_wait, 0, 0, 4'b1000, "drain_map");
  // back-pressure on ch1
  add_row(op_rdy,  0, 3'b101, 0, "ch1_blocked");
  add_row(op_evt,  1, 32'h0000_0350, 0, "bp_evt_a");
  add_row(op_evt,  1, 32'h0000_0360, 0, "bp_evt_b");
  add_row(op_evt,  1, 32'h0000_0370, 0, "bp_evt_c");
  add_row(op_wait, 0, 8, 4'b0010, "bp_stalled");
  add_row(op_rdy,  0, 3'b111, 0, "ch1_released");
  add_row(op_wait, 0, 0, 4'b1000, "bp_drain");
  // stop holds the source
  add_row(op_wr,   0, 1, 0, "stop_set");
  add_row(op_rd,   0, 0, 1, "stop_rd");
  add_row(op_evt,  0, 32'h0000_0120, 0, "evt_stopped");
  add_row(op_wait, 0, 6, 4'b0000, "stopped_status");
  add_row(op_wr,   0, 0, 0, "stop_clear");
  add_row(op_wait, 0, 0, 4'b1000, "stop_drain");
  // cfg packet moves entry 0 to ch1 only
  add_row(op_rx,   0, {8'h02, 32'h0000_0030, 32'h0000_0002}, 0, "rx_cfg_route0");
  add_row(op_rd,  48, 0, 3'b010, "route0_after_rx");
  add_row(op_evt,  0, 32'h0000_0120, 2, "evt_rerouted");
  add_row(op_wait, 0, 0, 4'b1000, "rx_drain");
  add_row(op_rx,   0, {8'h01, 32'h0000_0099, 32'hdead_beef}, 0, "rx_mc");
  add_row(op_rd,   1, 0, 1, "cnt_mc_rd");
  add_row(op_rd,   2, 0, 1, "cnt_cfg_rd");
endtask

//--- verification/tb_dvs_hssl.sv
// testbench top: clock, reset, DUT, register model, check task, table loop, tx monitor, watchdog
module tb_dvs_hssl;

  localparam int n_map = 4;
  localparam int n_rt  = 16;
  localparam int n_ch  = 3;

  typedef enum int {op_wr, op_rd, op_evt, op_rx, op_rdy, op_wait} op_e;

  logic                                pl_clk0_buf_int;
  logic                                rst_n;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [dvs_hssl_pkg::addr_bits-1:0]  paddr;
  logic [dvs_hssl_pkg::data_bits-1:0]  pwdata;
  logic [dvs_hssl_pkg::data_bits-1:0]  prdata;
  logic                                pslverr;
  logic [dvs_hssl_pkg::evt_bits-1:0]   evt_data;
  logic                                evt_vld;
  logic                                evt_rdy;
  logic [dvs_hssl_pkg::pkt_bits-1:0]   tx_data;
  logic [n_ch-1:0]                     tx_vld;
  logic [n_ch-1:0]                     tx_rdy;
  logic [dvs_hssl_pkg::pkt_bits-1:0]   rx_data;
  logic                                rx_vld;

  // table columns, one entry per row
  op_e         tbl_op   [$];
  int          tbl_addr [$];
  logic [71:0] tbl_data [$];
  logic [71:0] tbl_exp  [$];
  string       tbl_name [$];

  // register model, mirrors every write sent to the DUT
  logic [31:0] m_mask  [n_map];
  logic [2:0]  m_shift [n_map];
  logic [31:0] r_key   [n_rt];
  logic [31:0] r_mask  [n_rt];
  logic [2:0]  r_route [n_rt];

  // expected packets per channel, due cycle or -1 when latency is free
  logic [71:0] exp_q [n_ch][$];
  int          due_q [n_ch][$];
  // events waiting for the driver
  logic [31:0] evt_q [$];
  int          lat_q [$];
  logic [31:0] nxt_data;
  int          nxt_lat;
  int          cur_lat = 0;
  logic        busy = 1'b0;
  logic        load = 1'b0;

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          n_rows = 0;
  integer      seed = 49;

  dvs_hssl_top #(
      .num_mregs    (n_map)
    , .num_rregs    (n_rt)
    , .num_channels (n_ch)
  ) i_dvs_hssl_top (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .psel            (psel)
    , .penable         (penable)
    , .pwrite          (pwrite)
    , .paddr           (paddr)
    , .pwdata          (pwdata)
    , .prdata          (prdata)
    , .pslverr         (pslverr)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .tx_data         (tx_data)
    , .tx_vld          (tx_vld)
    , .tx_rdy          (tx_rdy)
    , .rx_data         (rx_data)
    , .rx_vld          (rx_vld)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check(input string name, input logic [71:0] exp, input logic [71:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_row(input op_e op, input int a, input logic [71:0] d,
                         input logic [71:0] e, input string name);
    tbl_op.push_back(op);
    tbl_addr.push_back(a);
    tbl_data.push_back(d);
    tbl_exp.push_back(e);
    tbl_name.push_back(name);
  endtask

  `include "tb_dvs_hssl_table.svh"

  // key rule: OR of every masked event field shifted right
  function automatic logic [31:0] map_key(input logic [31:0] evt);
    logic [31:0] k;
    k = '0;
    for (int i = 0; i < n_map; i++)
      k = k | ((evt & m_mask[i]) >> m_shift[i]);
    return k;
  endfunction

  // first entry whose masked key matches, else dropped
  function automatic logic [2:0] route_of(input logic [31:0] key);
    for (int i = 0; i < n_rt; i++)
      if ((key & r_mask[i]) == r_key[i])
        return r_route[i];
    return '0;
  endfunction

  function automatic logic is_mapped(input int a);
    return a <= dvs_hssl_pkg::addr_cnt_cfg
        || (a >= dvs_hssl_pkg::addr_map_mask && a < dvs_hssl_pkg::addr_map_mask + n_map)
        || (a >= dvs_hssl_pkg::addr_map_shift && a < dvs_hssl_pkg::addr_map_shift + n_map)
        || (a >= dvs_hssl_pkg::addr_rt_key && a < dvs_hssl_pkg::addr_rt_key + n_rt)
        || (a >= dvs_hssl_pkg::addr_rt_mask && a < dvs_hssl_pkg::addr_rt_mask + n_rt)
        || (a >= dvs_hssl_pkg::addr_rt_route && a < dvs_hssl_pkg::addr_rt_route + n_rt);
  endfunction

  task automatic model_write(input int a, input logic [31:0] d);
    for (int i = 0; i < n_map; i++) begin
      if (a == dvs_hssl_pkg::addr_map_mask + i)
        m_mask[i] = d;
      if (a == dvs_hssl_pkg::addr_map_shift + i)
        m_shift[i] = d[2:0];
    end
    for (int i = 0; i < n_rt; i++) begin
      if (a == dvs_hssl_pkg::addr_rt_key + i)
        r_key[i] = d;
      if (a == dvs_hssl_pkg::addr_rt_mask + i)
        r_mask[i] = d;
      if (a == dvs_hssl_pkg::addr_rt_route + i)
        r_route[i] = d[2:0];
    end
  endtask

  // setup then access cycle, read data taken at the closing edge
  task automatic apb_xfer(input logic wr, input int a, input logic [31:0] d,
                          output logic [31:0] rd, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = 8'(a);
    pwdata  = d;
    @(negedge pl_clk0_buf_int);
    penable = 1'b1;
    @(posedge pl_clk0_buf_int);
    rd  = prdata;
    err = pslverr;
    @(negedge pl_clk0_buf_int);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // ------------------------------------------------------------
  // tx monitor and event driver, one process per edge pair
  // ------------------------------------------------------------
  task automatic watch_tx();
    for (int c = 0; c < n_ch; c++) begin
      if (tx_vld[c] && exp_q[c].size() == 0) begin
        errors++;
        $display("unexpected packet on channel %0d at cycle %0d", c, cyc);
      end else if (tx_vld[c]) begin
        // held data must stay the head packet until taken
        check($sformatf("tx_data_ch%0d", c), exp_q[c][0], tx_data);
        if (tx_rdy[c]) begin
          if (due_q[c][0] >= 0)
            check($sformatf("latency_ch%0d", c), 72'(due_q[c][0]), 72'(cyc));
          void'(exp_q[c].pop_front());
          void'(due_q[c].pop_front());
        end
      end
    end
  endtask

  task automatic take_evt();
    logic [31:0] key;
    logic [2:0]  route;
    if (evt_vld && evt_rdy) begin
      key   = map_key(evt_data);
      route = route_of(key);
      for (int c = 0; c < n_ch; c++) begin
        if (route[c]) begin
          exp_q[c].push_back({8'(dvs_hssl_pkg::pkt_mc), key, evt_data});
          due_q[c].push_back(cur_lat == 0 ? -1 : cyc + cur_lat);
        end
      end
      busy = 1'b0;
    end
    if (!busy && evt_q.size() > 0) begin
      nxt_data = evt_q.pop_front();
      nxt_lat  = lat_q.pop_front();
      busy     = 1'b1;
      load     = 1'b1;
    end
  endtask

  // wait until every event is taken and every packet delivered
  task automatic drain(input string name);
    int n;
    n = 0;
    while ((evt_q.size() > 0 || busy || tx_vld != 0 || exp_q[0].size() > 0
            || exp_q[1].size() > 0 || exp_q[2].size() > 0) && n < 200) begin
      @(negedge pl_clk0_buf_int);
      n++;
    end
    if (n >= 200) begin
      errors++;
      $display("%s: packets still undelivered after 200 cycles", name);
    end
  endtask

  // ------------------------------------------------------------
  // clock, cycle count at each falling edge
  // ------------------------------------------------------------
  initial begin
    pl_clk0_buf_int = 1'b0;
    forever begin
      #50 pl_clk0_buf_int = 1'b1;
      #50 pl_clk0_buf_int = 1'b0;
      cyc++;
    end
  end

  initial begin
    evt_vld  = 1'b0;
    evt_data = '0;
    @(posedge rst_n);
    forever begin
      @(posedge pl_clk0_buf_int);
      watch_tx();
      take_evt();
      @(negedge pl_clk0_buf_int);
      if (load) begin
        evt_data = nxt_data;
        evt_vld  = 1'b1;
        cur_lat  = nxt_lat;
        load     = 1'b0;
      end else if (!busy) begin
        evt_vld = 1'b0;
      end
    end
  end

  // budget scales with the table length
  initial begin
    #1;
    #(n_rows * 50 * 100);
    $display("simulation timed out at cycle %0d", cyc);
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------------------
  // table loop
  // ------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        err;
    logic [31:0] d;
    int          n;
    load_table();
    n_rows = tbl_op.size();
    for (int i = 0; i < n_map; i++) begin
      m_mask[i]  = '0;
      m_shift[i] = '0;
    end
    for (int i = 0; i < n_rt; i++) begin
      r_key[i]   = '0;
      r_mask[i]  = '0;
      r_route[i] = '0;
    end
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    tx_rdy  = '1;
    rx_data = '0;
    rx_vld  = 1'b0;
    repeat (10) @(posedge pl_clk0_buf_int);
    @(negedge pl_clk0_buf_int);
    rst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      case (tbl_op[r])
        op_wr: begin
          apb_xfer(1'b1, tbl_addr[r], tbl_data[r][31:0], rd, err);
          model_write(tbl_addr[r], tbl_data[r][31:0]);
        end
        op_rd: begin
          apb_xfer(1'b0, tbl_addr[r], '0, rd, err);
          check(tbl_name[r], tbl_exp[r], 72'(rd));
          check({tbl_name[r], "_pslverr"}, is_mapped(tbl_addr[r]) ? 72'd0 : 72'd1, 72'(err));
        end
        op_evt: begin
          // address column 1 fills the bits outside the key field at random
          d = tbl_data[r][31:0];
          if (tbl_addr[r] == 1)
            d = ($random(seed) & ~32'h0000_0ff0) | d;
          evt_q.push_back(d);
          lat_q.push_back(int'(tbl_exp[r]));
        end
        op_rx: begin
          rx_data = tbl_data[r];
          rx_vld  = 1'b1;
          if (tbl_data[r][dvs_hssl_pkg::hdr_lsb +: 8] == 8'(dvs_hssl_pkg::pkt_cfg))
            model_write(int'(tbl_data[r][dvs_hssl_pkg::key_lsb +: 8]), tbl_data[r][31:0]);
          @(negedge pl_clk0_buf_int);
          rx_vld = 1'b0;
        end
        op_rdy: tx_rdy = tbl_data[r][n_ch-1:0];
        default: begin
          // zero cycles means wait for the pipeline to drain
          n = int'(tbl_data[r]);
          if (n == 0) begin
            drain(tbl_name[r]);
            n = 3;
          end
          repeat (n) @(posedge pl_clk0_buf_int);
          check(tbl_name[r], tbl_exp[r], 72'({evt_rdy, tx_vld}));
          @(negedge pl_clk0_buf_int);
        end
      endcase
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
